//--- logic/arena_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_cfg.svh"

module arena_top (
    input  wire logic                                Clk,
    input  wire logic                                rst,
    input  wire logic                                frame_tick,
    input  wire game_pkg::attack_t                   attack,
    input  wire game_pkg::pos_t [`ENEMY_NUM-1:0]     enemy_pos,
    input  wire game_pkg::enemy_mask_t               enemy_attack_on,
    input  wire logic                                godmode,
    input  wire logic                                score_hold,
    output game_pkg::enemy_mask_t                    alive,
    output logic [15:0]                              score,
    output logic [15:0]                              hits,
    output logic [9:0]                               player_damage,
    output logic                                     overflow
);
    import game_pkg::*;

    enemy_mask_t   hit_mask;
    enemy_mask_t   kill_mask;
    enemy_mask_t   strike_mask;
    frame_report_t report;
    frame_report_t queue_head;
    logic          report_push;
    logic          queue_pop;
    logic          queue_not_empty;

    for (genvar i = 0; i < `ENEMY_NUM; i++) begin : g_enemy
        enemy_combat #(
            .ENEMY_ID (i)
        ) u_enemy (
            .Clk        (Clk),
            .rst        (rst),
            .frame_tick (frame_tick),
            .attack     (attack),
            .pos        (enemy_pos[i]),
            .attack_on  (enemy_attack_on[i]),
            .godmode    (godmode),
            .alive      (alive[i]),
            .hit        (hit_mask[i]),
            .kill       (kill_mask[i]),
            .strike     (strike_mask[i])
        );
    end

    // Pulses are already one cycle after the tick
    assign report = '{hit: hit_mask, kill: kill_mask, strike: strike_mask};
    assign report_push = (report != '0);

    report_queue u_queue (
        .Clk       (Clk),
        .rst       (rst),
        .push      (report_push),
        .push_data (report),
        .pop       (queue_pop),
        .pop_data  (queue_head),
        .not_empty (queue_not_empty),
        .overflow  (overflow)
    );

    score_keeper u_score (
        .Clk           (Clk),
        .rst           (rst),
        .hold          (score_hold),
        .report        (queue_head),
        .available     (queue_not_empty),
        .pop           (queue_pop),
        .score         (score),
        .hits          (hits),
        .player_damage (player_damage)
    );

endmodule

`default_nettype wire

//--- logic/enemy_combat.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_cfg.svh"

module enemy_combat #(
    parameter int ENEMY_ID = 0
) (
    input  wire logic              Clk,
    input  wire logic              rst,
    input  wire logic              frame_tick,
    input  wire game_pkg::attack_t attack,
    input  wire game_pkg::pos_t    pos,
    input  wire logic              attack_on,
    input  wire logic              godmode,
    output logic                   alive,
    output logic                   hit,
    output logic                   kill,
    output logic                   strike
);
    import game_pkg::*;

    // Odd enemies stay down twice as long
    localparam int RESPAWN_DELAY = `RESPAWN_BASE * (1 + (ENEMY_ID % 2));
    localparam int CNT_W         = $clog2(RESPAWN_DELAY + 1);
    localparam int HEALTH_W      = $clog2(`ENEMY_FULL_HEALTH + 1);

    // Box math in signed 12 bit so the up and left boxes can go negative
    localparam logic signed [11:0] SHORT_S = 12'(`SWORD_SHORT);
    localparam logic signed [11:0] LONG_S  = 12'(`SWORD_LONG);
    localparam logic signed [11:0] W_S     = 12'(`ENEMY_W);
    localparam logic signed [11:0] H_S     = 12'(`ENEMY_H);

    logic [HEALTH_W-1:0] health;
    logic [CNT_W-1:0]    respawn_cnt;

    logic signed [11:0]  ex;
    logic signed [11:0]  ey;
    logic signed [11:0]  ax;
    logic signed [11:0]  ay;
    logic signed [11:0]  box_x_lo;
    logic signed [11:0]  box_x_hi;
    logic signed [11:0]  box_y_lo;
    logic signed [11:0]  box_y_hi;

    logic overlap;
    logic hit_now;
    logic kill_now;
    logic strike_now;
    logic respawn_now;

    assign alive = (health != '0);

    assign ex = $signed({3'b000, pos.x});
    assign ey = $signed({3'b000, pos.y});
    assign ax = $signed({3'b000, attack.pos.x});
    assign ay = $signed({3'b000, attack.pos.y});

    // Sword box placement around the sword point
    always_comb begin
        box_x_lo = ax;
        box_x_hi = ax + SHORT_S;
        box_y_lo = ay;
        box_y_hi = ay + LONG_S;
        case (attack.facing)
            FACE_DOWN: begin
                box_x_hi = ax + SHORT_S;
                box_y_lo = ay;
                box_y_hi = ay + LONG_S;
            end
            FACE_UP: begin
                box_x_hi = ax + SHORT_S;
                box_y_lo = ay - LONG_S;
                box_y_hi = ay;
            end
            FACE_LEFT: begin
                box_x_lo = ax - LONG_S;
                box_x_hi = ax;
                box_y_hi = ay + SHORT_S;
            end
            FACE_RIGHT: begin
                box_x_hi = ax + LONG_S;
                box_y_hi = ay + SHORT_S;
            end
        endcase
    end

    // Inclusive bounds on both axes
    assign overlap = (ex + W_S >= box_x_lo) && (ex <= box_x_hi) &&
                     (ey + H_S >= box_y_lo) && (ey <= box_y_hi);

    assign hit_now     = frame_tick && alive && attack.active && overlap;
    assign kill_now    = hit_now && (health <= HEALTH_W'(`PLAYER_DAMAGE));
    assign strike_now  = frame_tick && alive && attack_on && !godmode;
    assign respawn_now = frame_tick && !alive &&
                         (respawn_cnt == CNT_W'(RESPAWN_DELAY));

    // Starts dead so every enemy goes through a first respawn
    always_ff @(posedge Clk) begin
        if (rst) begin
            health      <= '0;
            respawn_cnt <= '0;
        end else if (respawn_now) begin
            respawn_cnt <= '0;
            health      <= HEALTH_W'(`ENEMY_FULL_HEALTH);
        end else if (frame_tick && !alive) begin
            respawn_cnt <= respawn_cnt + 1'b1;
        end else if (hit_now) begin
            if (kill_now) begin
                health <= '0;
            end else begin
                health <= health - HEALTH_W'(`PLAYER_DAMAGE);
            end
        end
    end

    // One cycle pulses after the tick
    always_ff @(posedge Clk) begin
        if (rst) begin
            hit    <= 1'b0;
            kill   <= 1'b0;
            strike <= 1'b0;
        end else begin
            hit    <= hit_now;
            kill   <= kill_now;
            strike <= strike_now;
        end
    end

endmodule

`default_nettype wire

//--- logic/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Number of enemy instances in the arena
`define ENEMY_NUM 4

// Enemy hit box
`define ENEMY_W 26
`define ENEMY_H 26

// Sword box sides, short across the swing and long along it
`define SWORD_SHORT 16
`define SWORD_LONG 80

// Health lost by an enemy per hit
`define PLAYER_DAMAGE 10
`define ENEMY_FULL_HEALTH 100

// Player damage per enemy strike
`define ENEMY_DAMAGE 10

// Respawn delay in frames, doubled for odd enemy ids
`define RESPAWN_BASE 40

// Frame report queue
`define QUEUE_DEPTH 4

`endif

//--- logic/game_pkg.sv
`default_nettype none
`include "game_cfg.svh"

package game_pkg;

    // Screen coordinates
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } pos_t;

    // Encoding matches the sprite direction field
    typedef enum logic [1:0] {
        FACE_DOWN  = 2'd0,
        FACE_LEFT  = 2'd1,
        FACE_UP    = 2'd2,
        FACE_RIGHT = 2'd3
    } facing_t;

    // Player swing
    typedef struct packed {
        pos_t    pos;
        facing_t facing;
        logic    active;
    } attack_t;

    // One bit per enemy, bit i for enemy i
    typedef logic [`ENEMY_NUM-1:0] enemy_mask_t;

    // Everything that happened on one frame tick
    typedef struct packed {
        enemy_mask_t hit;
        enemy_mask_t kill;
        enemy_mask_t strike;
    } frame_report_t;

endpackage

`default_nettype wire

//--- logic/report_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_cfg.svh"

module report_queue (
    input  wire logic                    Clk,
    input  wire logic                    rst,
    input  wire logic                    push,
    input  wire game_pkg::frame_report_t push_data,
    input  wire logic                    pop,
    output game_pkg::frame_report_t      pop_data,
    output logic                         not_empty,
    output logic                         overflow
);
    import game_pkg::*;

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    frame_report_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    // Head of the queue is always visible
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge Clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // Dropped report, flag holds until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/score_keeper.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_cfg.svh"

module score_keeper (
    input  wire logic                    Clk,
    input  wire logic                    rst,
    input  wire logic                    hold,
    input  wire game_pkg::frame_report_t report,
    input  wire logic                    available,
    output logic                         pop,
    output logic [15:0]                  score,
    output logic [15:0]                  hits,
    output logic [9:0]                   player_damage
);
    import game_pkg::*;

    localparam int CNT_W = $clog2(`ENEMY_NUM + 1);

    logic [CNT_W-1:0] kill_cnt;
    logic [CNT_W-1:0] hit_cnt;
    logic [CNT_W-1:0] strike_cnt;
    logic [10:0]      damage_sum;

    function automatic logic [CNT_W-1:0] count_ones(input enemy_mask_t mask);
        logic [CNT_W-1:0] total;
        int               i;
        total = '0;
        for (i = 0; i < `ENEMY_NUM; i++) begin
            total = total + CNT_W'(mask[i]);
        end
        return total;
    endfunction

    assign pop = available && !hold;

    assign kill_cnt   = count_ones(report.kill);
    assign hit_cnt    = count_ones(report.hit);
    assign strike_cnt = count_ones(report.strike);

    // Extra top bit catches the carry for saturation
    assign damage_sum = {1'b0, player_damage} + 11'(`ENEMY_DAMAGE * strike_cnt);

    always_ff @(posedge Clk) begin
        if (rst) begin
            score         <= '0;
            hits          <= '0;
            player_damage <= '0;
        end else if (pop) begin
            score <= score + 16'(kill_cnt);
            hits  <= hits + 16'(hit_cnt);
            if (damage_sum[10]) begin
                player_damage <= '1;
            end else begin
                player_damage <= damage_sum[9:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module arena_tb -o arena_sim

out=$(./obj_dir/arena_sim)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+logic
logic/game_pkg.sv
logic/enemy_combat.sv
logic/report_queue.sv
logic/score_keeper.sv
logic/arena_top.sv
test/arena_tb.sv

//--- test/arena_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "game_cfg.svh"

module arena_tb;
    import game_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int TICK_GAP    = 8;
    localparam int MAX_TICKS   = 600;
    localparam int WATCHDOG_NS = (MAX_TICKS * TICK_GAP + 400) * CLK_PERIOD;

    logic                         Clk;
    logic                         rst;
    logic                         frame_tick;
    attack_t                      attack;
    pos_t [`ENEMY_NUM-1:0]        enemy_pos;
    enemy_mask_t                  enemy_attack_on;
    logic                         godmode;
    logic                         score_hold;
    enemy_mask_t                  alive;
    logic [15:0]                  score;
    logic [15:0]                  hits;
    logic [9:0]                   player_damage;
    logic                         overflow;

    // Values for the next tick, applied on the clock edge
    attack_t                      nxt_attack;
    pos_t [`ENEMY_NUM-1:0]        nxt_pos;
    enemy_mask_t                  nxt_attack_on;
    logic                         nxt_godmode;
    logic                         nxt_hold;

    logic [31:0]                  lfsr_state = 32'h4c79_1d36;
    int                           errors = 0;

    // Reference model state
    int                           m_health [`ENEMY_NUM];
    int                           m_cnt [`ENEMY_NUM];
    enemy_mask_t                  m_alive;
    enemy_mask_t                  m_hit;
    enemy_mask_t                  m_kill;
    enemy_mask_t                  m_strike;
    frame_report_t                m_q [`QUEUE_DEPTH];
    int                           m_rd;
    int                           m_len;
    logic                         m_overflow;
    logic [15:0]                  m_score;
    logic [15:0]                  m_hits;
    int                           m_damage;

    arena_top DUT (
        .Clk             (Clk),
        .rst             (rst),
        .frame_tick      (frame_tick),
        .attack          (attack),
        .enemy_pos       (enemy_pos),
        .enemy_attack_on (enemy_attack_on),
        .godmode         (godmode),
        .score_hold      (score_hold),
        .alive           (alive),
        .score           (score),
        .hits            (hits),
        .player_damage   (player_damage),
        .overflow        (overflow)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | 32'(lfsr_state[0]);
        end
    endtask

    function automatic int ones(input enemy_mask_t m);
        int n;
        n = 0;
        for (int i = 0; i < `ENEMY_NUM; i++) begin
            n = n + int'(m[i]);
        end
        return n;
    endfunction

    function automatic int respawn_delay(input int id);
        return `RESPAWN_BASE * (1 + (id & 1));
    endfunction

    // Inclusive interval overlap of enemy box and sword box
    function automatic logic box_overlap(input attack_t a, input pos_t e);
        int ax;
        int ay;
        int sx0;
        int sx1;
        int sy0;
        int sy1;
        ax = int'(a.pos.x);
        ay = int'(a.pos.y);
        case (a.facing)
            FACE_DOWN: begin
                sx0 = ax;
                sx1 = ax + `SWORD_SHORT;
                sy0 = ay;
                sy1 = ay + `SWORD_LONG;
            end
            FACE_UP: begin
                sx0 = ax;
                sx1 = ax + `SWORD_SHORT;
                sy0 = ay - `SWORD_LONG;
                sy1 = ay;
            end
            FACE_LEFT: begin
                sx0 = ax - `SWORD_LONG;
                sx1 = ax;
                sy0 = ay;
                sy1 = ay + `SWORD_SHORT;
            end
            default: begin
                sx0 = ax;
                sx1 = ax + `SWORD_LONG;
                sy0 = ay;
                sy1 = ay + `SWORD_SHORT;
            end
        endcase
        return (int'(e.x) <= sx1) && (int'(e.x) + `ENEMY_W >= sx0) &&
               (int'(e.y) <= sy1) && (int'(e.y) + `ENEMY_H >= sy0);
    endfunction

    always_comb begin
        for (int i = 0; i < `ENEMY_NUM; i++) begin
            m_alive[i] = (m_health[i] != 0);
        end
    end

    always @(posedge Clk) begin
        frame_report_t rep;
        frame_report_t head;
        int            accept_n;
        int            pop_n;
        int            sum;
        if (rst) begin
            for (int i = 0; i < `ENEMY_NUM; i++) begin
                m_health[i] <= 0;
                m_cnt[i]    <= 0;
            end
            m_hit      <= '0;
            m_kill     <= '0;
            m_strike   <= '0;
            m_rd       <= 0;
            m_len      <= 0;
            m_overflow <= 1'b0;
            m_score    <= '0;
            m_hits     <= '0;
            m_damage   <= 0;
        end else begin
            for (int i = 0; i < `ENEMY_NUM; i++) begin
                m_hit[i]    <= 1'b0;
                m_kill[i]   <= 1'b0;
                m_strike[i] <= 1'b0;
                if (frame_tick && m_health[i] == 0) begin
                    if (m_cnt[i] == respawn_delay(i)) begin
                        m_cnt[i]    <= 0;
                        m_health[i] <= `ENEMY_FULL_HEALTH;
                    end else begin
                        m_cnt[i] <= m_cnt[i] + 1;
                    end
                end else if (frame_tick) begin
                    if (attack.active && box_overlap(attack, enemy_pos[i])) begin
                        m_hit[i] <= 1'b1;
                        if (m_health[i] <= `PLAYER_DAMAGE) begin
                            m_health[i] <= 0;
                            m_kill[i]   <= 1'b1;
                        end else begin
                            m_health[i] <= m_health[i] - `PLAYER_DAMAGE;
                        end
                    end
                    m_strike[i] <= enemy_attack_on[i] && !godmode;
                end
            end

            // Frame report from last cycle's pulses
            rep.hit    = m_hit;
            rep.kill   = m_kill;
            rep.strike = m_strike;
            accept_n   = (rep != '0 && m_len < `QUEUE_DEPTH) ? 1 : 0;
            pop_n      = (m_len > 0 && !score_hold) ? 1 : 0;
            if (rep != '0 && m_len == `QUEUE_DEPTH) begin
                m_overflow <= 1'b1;
            end
            if (accept_n == 1) begin
                m_q[(m_rd + m_len) % `QUEUE_DEPTH] <= rep;
            end
            if (pop_n == 1) begin
                head = m_q[m_rd];
                sum  = m_damage + `ENEMY_DAMAGE * ones(head.strike);
                m_score  <= m_score + 16'(ones(head.kill));
                m_hits   <= m_hits + 16'(ones(head.hit));
                m_damage <= (sum > 1023) ? 1023 : sum;
                m_rd     <= (m_rd + 1) % `QUEUE_DEPTH;
            end
            m_len <= m_len + accept_n - pop_n;
        end
    end

    alive_check: assert property (@(posedge Clk) disable iff (rst) alive == m_alive)
        else begin
            errors++;
            $display("FAIL %0t: alive %b, model %b", $time, alive, m_alive);
        end

    overflow_check: assert property (@(posedge Clk) disable iff (rst) overflow == m_overflow)
        else begin
            errors++;
            $display("FAIL %0t: overflow %b, model %b", $time, overflow, m_overflow);
        end

    // Totals are compared once the model queue has drained
    totals_check: assert property (@(posedge Clk) disable iff (rst)
        (m_len == 0) |-> (score == m_score && hits == m_hits &&
                          int'(player_damage) == m_damage))
        else begin
            errors++;
            $display("FAIL %0t: score %0d hits %0d damage %0d, model %0d %0d %0d",
                     $time, score, hits, player_damage, m_score, m_hits, m_damage);
        end

    task automatic stage_frame(input logic swing, input int god_sel, input logic hold,
                               input logic all_attack);
        int unsigned r;
        int unsigned ax;
        int unsigned ay;
        take_bits(6, r);
        ax = 150 + r;
        take_bits(6, r);
        ay = 150 + r;
        nxt_attack.pos.x = 9'(ax);
        nxt_attack.pos.y = 9'(ay);
        take_bits(2, r);
        nxt_attack.facing = facing_t'(r[1:0]);
        take_bits(2, r);
        nxt_attack.active = swing && (r != 0);
        // Enemies scattered within 64 pixels of the sword point
        for (int i = 0; i < `ENEMY_NUM; i++) begin
            take_bits(7, r);
            nxt_pos[i].x = 9'(ax + r - 64);
            take_bits(7, r);
            nxt_pos[i].y = 9'(ay + r - 64);
        end
        if (all_attack) begin
            nxt_attack_on = '1;
        end else begin
            take_bits(`ENEMY_NUM, r);
            nxt_attack_on = r[`ENEMY_NUM-1:0];
        end
        if (god_sel == 2) begin
            take_bits(1, r);
            nxt_godmode = r[0];
        end else begin
            nxt_godmode = (god_sel == 1);
        end
        nxt_hold = hold;
    endtask

    task automatic run_frame();
        @(posedge Clk);
        attack          <= nxt_attack;
        enemy_pos       <= nxt_pos;
        enemy_attack_on <= nxt_attack_on;
        godmode         <= nxt_godmode;
        score_hold      <= nxt_hold;
        frame_tick      <= 1'b1;
        @(posedge Clk);
        frame_tick <= 1'b0;
        repeat (TICK_GAP - 2) @(posedge Clk);
    endtask

    task automatic run_phase(input int frames, input logic swing, input int god_sel,
                             input logic hold, input logic all_attack);
        for (int f = 0; f < frames; f++) begin
            stage_frame(swing, god_sel, hold, all_attack);
            run_frame();
        end
    endtask

    initial begin
        Clk             = 1'b0;
        rst             = 1'b1;
        frame_tick      = 1'b0;
        attack          = '0;
        enemy_pos       = '0;
        enemy_attack_on = '0;
        godmode         = 1'b0;
        score_hold      = 1'b0;
        repeat (4) @(posedge Clk);
        rst <= 1'b0;

        // First respawns, strikes only from live enemies
        run_phase(81, 1'b0, 2, 1'b0, 1'b0);
        // Swings in every facing under godmode
        run_phase(300, 1'b1, 1, 1'b0, 1'b0);
        // Let everyone come back
        run_phase(82, 1'b0, 1, 1'b0, 1'b0);
        // Hold the score keeper until the queue overflows
        run_phase(8, 1'b0, 0, 1'b1, 1'b1);
        // Drain and push damage into saturation
        run_phase(30, 1'b0, 0, 1'b0, 1'b1);
        run_phase(2, 1'b0, 1, 1'b0, 1'b0);

        if (m_score == 0) begin
            errors++;
            $display("Stimulus never killed an enemy");
        end
        if (!m_overflow) begin
            errors++;
            $display("Stimulus never overflowed the report queue");
        end
        if (m_damage != 1023) begin
            errors++;
            $display("Stimulus never saturated the player damage");
        end

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
